/* logic/dbg_cfg.svh */
// Build constants of the debug I2C unit, included by every file that needs widths or the map
`ifndef DBG_CFG_SVH
`define DBG_CFG_SVH

// Datapath widths
`define DBG_ADDR_W        6          // Register address, bits 5..0 of the command byte
`define DBG_DATA_W        16         // Register word
`define DBG_MEM_DEPTH     64         // Debug memory words

// Identity returned by the ID register
`define DBG_ID_VALUE      16'h4D31

// Register map
`define DBG_REG_ID        6'h00      // Read-only
`define DBG_REG_SCRATCH0  6'h01
`define DBG_REG_SCRATCH1  6'h02
`define DBG_REG_MEM_ADDR  6'h05      // Memory index
`define DBG_REG_MEM_DATA  6'h06      // Memory port, index advances on each access

// Broadcast address matching, 1 enables it
`define DBG_I2C_BROADCAST 1'b1

`endif

/* logic/dbg_pkg.sv */
// Shared types of the debug I2C unit, referenced by scoped name from every RTL file
`include "dbg_cfg.svh"

package dbg_pkg;

  // ==========================================================
  // Vector types
  // ==========================================================
  typedef logic [`DBG_ADDR_W-1:0]             dbg_addr_t;      // Register address
  typedef logic [`DBG_DATA_W-1:0]             dbg_word_t;      // Register data
  typedef logic [7:0]                         dbg_byte_t;      // One I2C byte
  typedef logic [6:0]                         i2c_dev_addr_t;  // 7-bit device address
  typedef logic [$clog2(`DBG_MEM_DEPTH)-1:0]  mem_idx_t;       // Memory index

  // ==========================================================
  // State machines
  // ==========================================================

  // Bit level protocol engine
  typedef enum logic [2:0] {
    RX_ADDR, RX_ADDR_ACK, RX_DATA, RX_DATA_ACK, TX_DATA, TX_DATA_ACK
  } i2c_state_e;

  // Debug command sequencer
  typedef enum logic [2:0] {
    RX_CMD, RX_BYTE_LO, RX_BYTE_HI, TX_BYTE_LO, TX_BYTE_HI
  } dbg_state_e;

endpackage

/* logic/dbg_i2c_line_filter.sv */
// Brings the raw I2C pins into dbg_clk, votes out glitches and flags edges, START and STOP
`timescale 1ns/1ns

module dbg_i2c_line_filter (
  input  logic dbg_clk,
  input  logic dbg_rst,
  input  logic scl_pin,       // Raw bus lines
  input  logic sda_pin,
  output logic scl,           // Filtered levels
  output logic sda_in,
  output logic scl_fe,        // One-cycle edge pulses
  output logic scl_re,
  output logic scl_sample,    // Data sample point, 2 cycles after scl_re
  output logic sda_in_re,
  output logic start_detect,
  output logic stop_detect
);

  // Bit 1 carries SCL, bit 0 carries SDA
  logic [1:0] sync_q1;
  logic [1:0] sync_q2;
  logic [1:0] hist_q0;
  logic [1:0] hist_q1;
  logic [1:0] maj;
  logic [1:0] maj_dly;
  logic [1:0] scl_re_dly;
  logic       sda_in_fe;

  // ==========================================================
  // Synchronizer and majority vote
  // ==========================================================

  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst) begin
      sync_q1 <= 2'b11;           // Idle bus reads high
      sync_q2 <= 2'b11;
      hist_q0 <= 2'b11;
      hist_q1 <= 2'b11;
    end else begin
      sync_q1 <= {scl_pin, sda_pin};
      sync_q2 <= sync_q1;
      hist_q0 <= sync_q2;         // Sample history for the vote
      hist_q1 <= hist_q0;
    end
  end

  // Two of three samples win, per line
  assign maj = (sync_q2 & hist_q0) | (sync_q2 & hist_q1) | (hist_q0 & hist_q1);

  // ==========================================================
  // Edge detection
  // ==========================================================

  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst) begin
      maj_dly    <= 2'b11;
      scl_re_dly <= 2'b00;
    end else begin
      maj_dly    <= maj;
      scl_re_dly <= {scl_re_dly[0], scl_re};   // Lets SDA settle before sampling
    end
  end

  assign scl        = maj[1];
  assign sda_in     = maj[0];
  assign scl_fe     = maj_dly[1] & ~maj[1];
  assign scl_re     = ~maj_dly[1] & maj[1];
  assign sda_in_fe  = maj_dly[0] & ~maj[0];
  assign sda_in_re  = ~maj_dly[0] & maj[0];
  assign scl_sample = scl_re_dly[1];

  // SDA moving while SCL is high marks bus conditions
  assign start_detect = sda_in_fe & scl;
  assign stop_detect  = sda_in_re & scl;

endmodule

/* logic/dbg_i2c_slave.sv */
// I2C slave engine, decodes debug commands into one-cycle register write and read strobes
`timescale 1ns/1ns
`include "dbg_cfg.svh"

module dbg_i2c_slave (
  input  logic                   dbg_clk,
  input  logic                   dbg_rst,
  input  logic                   scl,             // Filtered bus from the line filter
  input  logic                   sda_in,
  input  logic                   scl_fe,
  input  logic                   scl_re,
  input  logic                   scl_sample,
  input  logic                   sda_in_re,
  input  logic                   start_detect,
  input  logic                   stop_detect,
  input  dbg_pkg::i2c_dev_addr_t dev_addr,        // Own address
  input  dbg_pkg::i2c_dev_addr_t broadcast_addr,
  input  dbg_pkg::dbg_word_t     dbg_dout,        // Register bank read data
  output dbg_pkg::dbg_addr_t     dbg_addr,
  output dbg_pkg::dbg_word_t     dbg_din,
  output logic                   dbg_wr,
  output logic                   dbg_rd,
  output logic                   sda_out          // 0 pulls SDA low, 1 releases
);

  dbg_pkg::i2c_state_e i2c_state;
  dbg_pkg::i2c_state_e i2c_state_nxt;
  dbg_pkg::dbg_state_e dbg_state;
  dbg_pkg::dbg_state_e dbg_state_nxt;

  logic [8:0]         shift_buf;        // Byte with a marker bit below it
  logic [8:0]         shift_buf_nxt;
  logic               i2c_active_seq;
  logic               i2c_active;
  logic               i2c_init;
  logic               addr_match;
  logic               addr_not_valid;
  logic               mst_ack;          // Master acknowledged our byte
  logic               shift_rx_en;
  logic               shift_tx_en_pre;
  logic               shift_rx_done;
  logic               shift_tx_done;
  logic               rx_init;
  logic               tx_init;
  logic               rx_shift;
  logic               tx_shift;
  logic               rx_data_done;
  logic               cmd_valid;
  logic               rx_lo_valid;
  logic               rx_hi_valid;
  logic               dbg_bw;           // Byte width command
  dbg_pkg::dbg_byte_t shift_tx_val;
  dbg_pkg::dbg_byte_t din_lo;
  dbg_pkg::dbg_byte_t din_hi;

  // ==========================================================
  // Sequence tracking
  // ==========================================================

  // Own address, or the broadcast one when enabled
  assign addr_match = (shift_buf[7:1] == dev_addr) ||
                      (`DBG_I2C_BROADCAST && (shift_buf[7:1] == broadcast_addr));
  assign addr_not_valid = (i2c_state == dbg_pkg::RX_ADDR) && shift_rx_done && !addr_match;

  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst)
      i2c_active_seq <= 1'b0;
    else if (start_detect)
      i2c_active_seq <= 1'b1;
    else if (stop_detect || addr_not_valid)
      i2c_active_seq <= 1'b0;                 // Other device addressed, stay off the bus
  end

  assign i2c_active = i2c_active_seq & ~stop_detect;
  assign i2c_init   = ~i2c_active | start_detect;   // Repeated START restarts too

  // ==========================================================
  // Protocol FSM
  // ==========================================================

  always_comb begin
    i2c_state_nxt = i2c_state;
    if (i2c_init) begin
      i2c_state_nxt = dbg_pkg::RX_ADDR;
    end else begin
      case (i2c_state)
        dbg_pkg::RX_ADDR:
          if (shift_rx_done && addr_match) i2c_state_nxt = dbg_pkg::RX_ADDR_ACK;
        dbg_pkg::RX_ADDR_ACK:                 // R/W bit picks the direction
          if (scl_fe) i2c_state_nxt = shift_buf[0] ? dbg_pkg::TX_DATA : dbg_pkg::RX_DATA;
        dbg_pkg::RX_DATA:
          if (shift_rx_done) i2c_state_nxt = dbg_pkg::RX_DATA_ACK;
        dbg_pkg::RX_DATA_ACK:
          if (scl_fe) i2c_state_nxt = dbg_pkg::RX_DATA;
        dbg_pkg::TX_DATA:
          if (shift_tx_done) i2c_state_nxt = dbg_pkg::TX_DATA_ACK;
        dbg_pkg::TX_DATA_ACK:                 // NACK ends the read
          if (scl_fe) i2c_state_nxt = mst_ack ? dbg_pkg::TX_DATA : dbg_pkg::RX_ADDR;
        default:
          i2c_state_nxt = dbg_pkg::RX_ADDR;
      endcase
    end
  end

  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst) i2c_state <= dbg_pkg::RX_ADDR;
    else         i2c_state <= i2c_state_nxt;
  end

  // Master ACK sampled mid-bit, an SDA release cancels it
  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst)
      mst_ack <= 1'b0;
    else if (scl_sample && (i2c_state == dbg_pkg::TX_DATA_ACK))
      mst_ack <= ~sda_in;
    else if (sda_in_re)
      mst_ack <= 1'b0;
  end

  // ==========================================================
  // Shift buffer
  // ==========================================================

  assign shift_rx_en     = (i2c_state == dbg_pkg::RX_ADDR) || (i2c_state == dbg_pkg::RX_DATA);
  assign shift_tx_en_pre = (i2c_state_nxt == dbg_pkg::TX_DATA) ||
                           (i2c_state_nxt == dbg_pkg::TX_DATA_ACK);

  // Marker reaching bit 8 means eight bits in, or eight bits out
  assign shift_rx_done = shift_rx_en & scl_fe & shift_buf[8];
  assign shift_tx_done = (i2c_state == dbg_pkg::TX_DATA) & scl_fe & (shift_buf == 9'h100);

  assign rx_init  = i2c_init |
                    ((i2c_state == dbg_pkg::RX_ADDR_ACK) & scl_fe & ~shift_buf[0]) |
                    ((i2c_state == dbg_pkg::RX_DATA_ACK) & scl_fe);
  assign tx_init  = scl_re & (((i2c_state == dbg_pkg::RX_ADDR_ACK) & shift_buf[0]) |
                              (i2c_state == dbg_pkg::TX_DATA_ACK));
  assign rx_shift = shift_rx_en & scl_sample & scl;     // SCL must still be high
  assign tx_shift = shift_tx_en_pre & scl_fe & (shift_buf != 9'h100);

  always_comb begin
    if (rx_init)       shift_buf_nxt = 9'h001;
    else if (tx_init)  shift_buf_nxt = {shift_tx_val, 1'b1};
    else if (rx_shift) shift_buf_nxt = {shift_buf[7:0], sda_in};
    else if (tx_shift) shift_buf_nxt = {shift_buf[7:0], 1'b0};    // MSB leaves first
    else               shift_buf_nxt = shift_buf;
  end

  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst) shift_buf <= 9'h001;
    else         shift_buf <= shift_buf_nxt;
  end

  // SDA moves only while SCL is low, ACK or transmitted zero pulls it
  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst)
      sda_out <= 1'b1;
    else if (scl_fe)
      sda_out <= ~((i2c_state_nxt == dbg_pkg::RX_ADDR_ACK) ||
                   (i2c_state_nxt == dbg_pkg::RX_DATA_ACK) ||
                   (tx_shift && !shift_buf[8]));
  end

  // ==========================================================
  // Debug command sequencer
  // ==========================================================

  assign rx_data_done = shift_rx_done & (i2c_state == dbg_pkg::RX_DATA);
  assign cmd_valid    = rx_data_done & (dbg_state == dbg_pkg::RX_CMD);
  assign rx_lo_valid  = rx_data_done & (dbg_state == dbg_pkg::RX_BYTE_LO);
  assign rx_hi_valid  = rx_data_done & (dbg_state == dbg_pkg::RX_BYTE_HI);

  always_comb begin
    dbg_state_nxt = dbg_state;
    case (dbg_state)
      dbg_pkg::RX_CMD:        // Bit 7 is write
        if (rx_data_done) dbg_state_nxt = shift_buf[7] ? dbg_pkg::RX_BYTE_LO : dbg_pkg::TX_BYTE_LO;
      dbg_pkg::RX_BYTE_LO:
        if (rx_data_done) dbg_state_nxt = dbg_bw ? dbg_pkg::RX_CMD : dbg_pkg::RX_BYTE_HI;
      dbg_pkg::RX_BYTE_HI:
        if (rx_data_done) dbg_state_nxt = dbg_pkg::RX_CMD;
      dbg_pkg::TX_BYTE_LO:
        if (shift_tx_done) dbg_state_nxt = dbg_bw ? dbg_pkg::RX_CMD : dbg_pkg::TX_BYTE_HI;
      dbg_pkg::TX_BYTE_HI:
        if (shift_tx_done) dbg_state_nxt = dbg_pkg::RX_CMD;
      default:
        dbg_state_nxt = dbg_pkg::RX_CMD;
    endcase
  end

  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst)          dbg_state <= dbg_pkg::RX_CMD;
    else if (stop_detect) dbg_state <= dbg_pkg::RX_CMD;   // STOP aborts a partial command
    else                  dbg_state <= dbg_state_nxt;
  end

  // Address and width held from the command byte
  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst) begin
      dbg_bw   <= 1'b0;
      dbg_addr <= '0;
    end else if (cmd_valid) begin
      dbg_bw   <= shift_buf[6];
      dbg_addr <= shift_buf[`DBG_ADDR_W-1:0];
    end
  end

  // Write data, low byte first
  always_ff @(posedge dbg_clk) begin
    if (rx_lo_valid) begin
      din_lo <= shift_buf[7:0];
      din_hi <= '0;                 // Byte write zero-extends
    end else if (rx_hi_valid) begin
      din_hi <= shift_buf[7:0];
    end
  end

  assign dbg_din = {din_hi, din_lo};

  // Strobes, one cycle after the closing SCL falling edge
  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst) begin
      dbg_wr <= 1'b0;
      dbg_rd <= 1'b0;
    end else begin
      dbg_wr <= dbg_bw ? rx_lo_valid : rx_hi_valid;
      dbg_rd <= cmd_valid & ~shift_buf[7];
    end
  end

  assign shift_tx_val = (dbg_state == dbg_pkg::TX_BYTE_HI) ? dbg_dout[15:8] : dbg_dout[7:0];

endmodule

/* logic/dbg_reg_bank.sv */
// Debug register bank, scratch registers plus the auto-incrementing debug memory
`timescale 1ns/1ns
`include "dbg_cfg.svh"

module dbg_reg_bank (
  input  logic               dbg_clk,
  input  logic               dbg_rst,
  input  dbg_pkg::dbg_addr_t dbg_addr,     // Held from the command byte
  input  dbg_pkg::dbg_word_t dbg_din,
  input  logic               dbg_wr,       // One-cycle strobes
  input  logic               dbg_rd,
  output dbg_pkg::dbg_word_t dbg_dout
);

  dbg_pkg::dbg_word_t scratch0;
  dbg_pkg::dbg_word_t scratch1;
  dbg_pkg::dbg_word_t rd_hold;          // MEM_DATA read value
  dbg_pkg::mem_idx_t  mem_idx;
  dbg_pkg::mem_idx_t  mem_idx_inc;
  dbg_pkg::dbg_word_t mem [`DBG_MEM_DEPTH];
  logic               sel_mem_data;
  logic               mem_wr;
  logic               mem_rd;

  assign sel_mem_data = (dbg_addr == `DBG_REG_MEM_DATA);
  assign mem_wr       = dbg_wr & sel_mem_data;
  assign mem_rd       = dbg_rd & sel_mem_data;

  // Wraps at the memory depth
  assign mem_idx_inc = (mem_idx == dbg_pkg::mem_idx_t'(`DBG_MEM_DEPTH - 1)) ? '0 :
                       mem_idx + 1'b1;

  // ==========================================================
  // Scratch registers
  // ==========================================================

  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst) begin
      scratch0 <= '0;
      scratch1 <= '0;
    end else if (dbg_wr) begin
      case (dbg_addr)
        `DBG_REG_SCRATCH0: scratch0 <= dbg_din;
        `DBG_REG_SCRATCH1: scratch1 <= dbg_din;
        default: ;                      // ID and unmapped ignore writes
      endcase
    end
  end

  // ==========================================================
  // Debug memory
  // ==========================================================

  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst)
      mem_idx <= '0;
    else if (dbg_wr && (dbg_addr == `DBG_REG_MEM_ADDR))
      mem_idx <= dbg_pkg::mem_idx_t'(dbg_din);   // Upper bits dropped
    else if (mem_wr || mem_rd)
      mem_idx <= mem_idx_inc;                    // Step on every data access
  end

  always_ff @(posedge dbg_clk) begin
    if (mem_wr)
      mem[mem_idx] <= dbg_din;
    if (mem_rd)
      rd_hold <= mem[mem_idx];      // Valid well before the next SCL rise
  end

  // Read mux on the held address
  always_comb begin
    case (dbg_addr)
      `DBG_REG_ID:       dbg_dout = `DBG_ID_VALUE;
      `DBG_REG_SCRATCH0: dbg_dout = scratch0;
      `DBG_REG_SCRATCH1: dbg_dout = scratch1;
      `DBG_REG_MEM_ADDR: dbg_dout = dbg_pkg::dbg_word_t'(mem_idx);
      `DBG_REG_MEM_DATA: dbg_dout = rd_hold;
      default:           dbg_dout = '0;           // Unmapped
    endcase
  end

endmodule

/* logic/dbg_i2c_top.sv */
// Top of the debug I2C access path, joining the line filter, slave engine and register bank
`timescale 1ns/1ns

module dbg_i2c_top (
  input  logic                   dbg_clk,
  input  logic                   dbg_rst,
  input  logic                   scl_pin,          // Bus pins, SDA as seen on the wire
  input  logic                   sda_pin,
  input  dbg_pkg::i2c_dev_addr_t dev_addr,
  input  dbg_pkg::i2c_dev_addr_t broadcast_addr,
  output logic                   sda_out           // Open-drain drive, 0 pulls low
);

  // Filtered bus
  logic scl;
  logic sda_in;
  logic scl_fe;
  logic scl_re;
  logic scl_sample;
  logic sda_in_re;
  logic start_detect;
  logic stop_detect;

  // Register access
  dbg_pkg::dbg_addr_t dbg_addr;
  dbg_pkg::dbg_word_t dbg_din;
  dbg_pkg::dbg_word_t dbg_dout;
  logic               dbg_wr;
  logic               dbg_rd;

  dbg_i2c_line_filter i_filter (
    .dbg_clk      (dbg_clk),
    .dbg_rst      (dbg_rst),
    .scl_pin      (scl_pin),
    .sda_pin      (sda_pin),
    .scl          (scl),
    .sda_in       (sda_in),
    .scl_fe       (scl_fe),
    .scl_re       (scl_re),
    .scl_sample   (scl_sample),
    .sda_in_re    (sda_in_re),
    .start_detect (start_detect),
    .stop_detect  (stop_detect)
  );

  dbg_i2c_slave i_slave (
    .dbg_clk        (dbg_clk),
    .dbg_rst        (dbg_rst),
    .scl            (scl),
    .sda_in         (sda_in),
    .scl_fe         (scl_fe),
    .scl_re         (scl_re),
    .scl_sample     (scl_sample),
    .sda_in_re      (sda_in_re),
    .start_detect   (start_detect),
    .stop_detect    (stop_detect),
    .dev_addr       (dev_addr),
    .broadcast_addr (broadcast_addr),
    .dbg_dout       (dbg_dout),
    .dbg_addr       (dbg_addr),
    .dbg_din        (dbg_din),
    .dbg_wr         (dbg_wr),
    .dbg_rd         (dbg_rd),
    .sda_out        (sda_out)
  );

  dbg_reg_bank i_regs (
    .dbg_clk  (dbg_clk),
    .dbg_rst  (dbg_rst),
    .dbg_addr (dbg_addr),
    .dbg_din  (dbg_din),
    .dbg_wr   (dbg_wr),
    .dbg_rd   (dbg_rd),
    .dbg_dout (dbg_dout)
  );

endmodule

/* verif/dbg_i2c_assert.sv */
// Protocol checks on the I2C slave engine, bound into dbg_i2c_slave from the testbench
`timescale 1ns/1ns

module dbg_i2c_assert (
  input logic dbg_clk,
  input logic dbg_rst,
  input logic scl_fe,        // Filtered SCL falling edge
  input logic sda_out,       // Open-drain drive, 0 pulls low
  input logic dbg_wr,
  input logic dbg_rd,
  input logic active_seq     // Slave owns the current bus sequence
);

  // ============================================================
  // Register strobes
  // ============================================================

  // Write and read never share a cycle
  strobe_excl: assert property (@(posedge dbg_clk) disable iff (dbg_rst)
    !(dbg_wr && dbg_rd))
    else $error("dbg_wr and dbg_rd high in the same cycle");

  wr_pulse: assert property (@(posedge dbg_clk) disable iff (dbg_rst)
    dbg_wr |=> !dbg_wr)       // One-cycle strobe
    else $error("dbg_wr held longer than one cycle");

  rd_pulse: assert property (@(posedge dbg_clk) disable iff (dbg_rst)
    dbg_rd |=> !dbg_rd)
    else $error("dbg_rd held longer than one cycle");

  // ============================================================
  // SDA drive
  // ============================================================

  // SDA only moves while SCL is low
  sda_on_fe: assert property (@(posedge dbg_clk) disable iff (dbg_rst)
    (sda_out != $past(sda_out)) |-> $past(scl_fe))
    else $error("sda_out changed without a preceding SCL falling edge");

  sda_idle: assert property (@(posedge dbg_clk) disable iff (dbg_rst)
    !active_seq |-> sda_out)  // Hands off when not addressed
    else $error("sda_out pulled low outside an active sequence");

endmodule

/* verif/tb_dbg_i2c.sv */
// Testbench of the debug I2C unit, acts as bus master and checks reads against a register model
`timescale 1ns/1ns
`include "dbg_cfg.svh"

module tb_dbg_i2c;

  localparam int HALF            = 8;                 // dbg_clk cycles per SCL half period
  localparam int BYTE_COUNT      = 147;               // Bytes moved by the whole suite
  localparam int CYCLES_PER_BYTE = 9 * 2 * HALF + 2 * HALF;   // Nine bits plus START/STOP share
  localparam int TIMEOUT         = 3 * BYTE_COUNT * CYCLES_PER_BYTE;

  logic                   dbg_clk;
  logic                   dbg_rst;
  logic                   scl_drv;           // Master side of the bus
  logic                   sda_drv;
  logic                   scl_pin;
  logic                   sda_pin;
  logic                   sda_out;
  dbg_pkg::i2c_dev_addr_t dev_addr;
  dbg_pkg::i2c_dev_addr_t broadcast_addr;

  // Register model
  logic [15:0] ref_s0;
  logic [15:0] ref_s1;
  logic [15:0] ref_mem [`DBG_MEM_DEPTH];
  logic [5:0]  ref_idx;

  logic [15:0] exp_q [$];                    // Read results waiting for the compare process
  logic [15:0] obs_q [$];
  string       name_q [$];
  logic [31:0] lcg_state;
  int          checks;
  int          errors;
  int          tests;
  int          test_base;
  int          cycles;

  assign scl_pin = scl_drv;
  assign sda_pin = sda_drv & sda_out;        // Wired AND of master and slave

  dbg_i2c_top i_dut (
    .dbg_clk        (dbg_clk),
    .dbg_rst        (dbg_rst),
    .scl_pin        (scl_pin),
    .sda_pin        (sda_pin),
    .dev_addr       (dev_addr),
    .broadcast_addr (broadcast_addr),
    .sda_out        (sda_out)
  );

  bind dbg_i2c_slave dbg_i2c_assert i_assert (
    .dbg_clk    (dbg_clk),
    .dbg_rst    (dbg_rst),
    .scl_fe     (scl_fe),
    .sda_out    (sda_out),
    .dbg_wr     (dbg_wr),
    .dbg_rd     (dbg_rd),
    .active_seq (i2c_active_seq)
  );

  initial begin
    dbg_clk = 1'b0;
    forever #50 dbg_clk = ~dbg_clk;          // 100 ns period
  end

  // ============================================================
  // Random data and reference model
  // ============================================================

  function automatic logic [15:0] lcg_word();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[31:16];                 // Upper bits are the better ones
  endfunction

  // Applies a write, or returns the expected word of a read
  function automatic logic [15:0] ref_access(input logic wr, input logic bw,
                                             input logic [5:0] addr, input logic [15:0] wdata);
    logic [15:0] val;
    val = bw ? {8'h00, wdata[7:0]} : wdata;  // Byte writes zero-extend
    ref_access = 16'h0000;
    if (wr) begin
      case (addr)
        `DBG_REG_SCRATCH0: ref_s0 = val;
        `DBG_REG_SCRATCH1: ref_s1 = val;
        `DBG_REG_MEM_ADDR: ref_idx = val[5:0];
        `DBG_REG_MEM_DATA: begin
          ref_mem[ref_idx] = val;
          ref_idx = ref_idx + 6'd1;          // Wraps past 63
        end
        default: ;                           // ID is read-only
      endcase
    end else begin
      case (addr)
        `DBG_REG_ID:       ref_access = `DBG_ID_VALUE;
        `DBG_REG_SCRATCH0: ref_access = ref_s0;
        `DBG_REG_SCRATCH1: ref_access = ref_s1;
        `DBG_REG_MEM_ADDR: ref_access = {10'h000, ref_idx};
        `DBG_REG_MEM_DATA: begin
          ref_access = ref_mem[ref_idx];
          ref_idx = ref_idx + 6'd1;
        end
        default:           ref_access = 16'h0000;
      endcase
    end
  endfunction

  // ============================================================
  // I2C master
  // ============================================================

  task automatic wait_clk(input int n);
    repeat (n) @(posedge dbg_clk);
  endtask

  // One SCL pulse, SDA set mid low phase, bus level taken late in the high phase
  task automatic clock_bit(input logic b, output logic seen);
    sda_drv <= b;
    wait_clk(HALF / 2);
    scl_drv <= 1'b1;
    wait_clk(HALF);
    seen = sda_pin;
    scl_drv <= 1'b0;
    wait_clk(HALF / 2);
  endtask

  task automatic bus_start();
    sda_drv <= 1'b1;
    wait_clk(HALF / 2);
    scl_drv <= 1'b1;
    wait_clk(HALF);
    sda_drv <= 1'b0;                         // SDA falls with SCL high
    wait_clk(HALF);
    scl_drv <= 1'b0;
    wait_clk(HALF / 2);
  endtask

  task automatic bus_stop();
    sda_drv <= 1'b0;
    wait_clk(HALF / 2);
    scl_drv <= 1'b1;
    wait_clk(HALF);
    sda_drv <= 1'b1;                         // SDA rises with SCL high
    wait_clk(HALF);
  endtask

  task automatic send_byte(input logic [7:0] b, output logic ack);
    logic seen;
    int   i;
    for (i = 7; i >= 0; i--) begin
      clock_bit(b[i], seen);
    end
    clock_bit(1'b1, seen);                   // Released for the slave
    ack = ~seen;
  endtask

  task automatic recv_byte(input logic ack, output logic [7:0] b);
    logic seen;
    int   i;
    for (i = 7; i >= 0; i--) begin
      clock_bit(1'b1, seen);
      b[i] = seen;
    end
    clock_bit(~ack, seen);                   // Master ACK or NACK
  endtask

  task automatic check_ack(input logic ack, input logic exp);
    checks++;
    if (ack !== exp) begin
      errors++;
      $display("** Error %0t: sda_pin on 9th bit expected %b got %b", $time, ~exp, ~ack);
    end
  endtask

  task automatic reg_write(input logic [6:0] dev, input logic bw, input logic [5:0] addr,
                           input logic [15:0] data);
    logic ack;
    bus_start();
    send_byte({dev, 1'b0}, ack);
    check_ack(ack, 1'b1);
    send_byte({1'b1, bw, addr}, ack);        // Write command
    check_ack(ack, 1'b1);
    send_byte(data[7:0], ack);
    check_ack(ack, 1'b1);
    if (!bw) begin
      send_byte(data[15:8], ack);
      check_ack(ack, 1'b1);
    end
    bus_stop();
    void'(ref_access(1'b1, bw, addr, data));
  endtask

  task automatic reg_read(input logic [6:0] dev, input logic bw, input logic [5:0] addr,
                          input string name);
    logic        ack;
    logic [7:0]  lo;
    logic [7:0]  hi;
    logic [15:0] exp;
    bus_start();
    send_byte({dev, 1'b0}, ack);
    check_ack(ack, 1'b1);
    send_byte({1'b0, bw, addr}, ack);        // Read command
    check_ack(ack, 1'b1);
    bus_start();                             // Repeated START turns the bus around
    send_byte({dev, 1'b1}, ack);
    check_ack(ack, 1'b1);
    hi = 8'h00;
    recv_byte(!bw, lo);                      // Low byte first
    if (!bw)
      recv_byte(1'b0, hi);
    bus_stop();
    exp = ref_access(1'b0, bw, addr, 16'h0000);
    if (bw)
      exp[15:8] = 8'h00;                     // Only one byte on the bus
    exp_q.push_back(exp);
    obs_q.push_back({hi, lo});
    name_q.push_back(name);
  endtask

  task automatic end_test(input string title);
    wait_clk(2);                             // Compare process catches up
    tests++;
    if (errors == test_base)
      $display("test %0d (%s): PASS", tests, title);
    else
      $display("test %0d (%s): FAIL with %0d errors", tests, title, errors - test_base);
    test_base = errors;
  endtask

  // ============================================================
  // Compare and timeout
  // ============================================================

  initial begin : compare_proc
    logic [15:0] exp;
    logic [15:0] obs;
    string       name;
    forever begin
      @(posedge dbg_clk);
      while (obs_q.size() > 0) begin
        exp  = exp_q.pop_front();
        obs  = obs_q.pop_front();
        name = name_q.pop_front();
        checks++;
        if (obs !== exp) begin
          errors++;
          $display("** Error %0t: %s expected %h got %h", $time, name, exp, obs);
        end
      end
    end
  end

  always @(posedge dbg_clk) begin
    cycles <= cycles + 1;
    if (cycles == TIMEOUT) begin
      $display("Timeout: run stopped after %0d cycles", cycles);
      $display("tests failed");
      $finish;
    end
  end

  // ============================================================
  // Test sequence
  // ============================================================

  initial begin
    logic ack;
    int   i;
    dbg_rst        = 1'b1;
    scl_drv        = 1'b1;                   // Idle bus
    sda_drv        = 1'b1;
    dev_addr       = 7'h2A;
    broadcast_addr = 7'h00;
    lcg_state      = 32'd87845;
    ref_s0         = 16'h0000;               // Reset state of the model
    ref_s1         = 16'h0000;
    ref_idx        = 6'd0;
    wait_clk(4);
    dbg_rst <= 1'b0;
    wait_clk(4);

    reg_write(dev_addr, 1'b0, `DBG_REG_SCRATCH0, lcg_word());
    reg_read(dev_addr, 1'b0, `DBG_REG_SCRATCH0, "sda_pin word read of SCRATCH0");
    end_test("word write and read of SCRATCH0");

    reg_write(dev_addr, 1'b0, `DBG_REG_SCRATCH1, lcg_word());   // High byte set first
    reg_write(dev_addr, 1'b1, `DBG_REG_SCRATCH1, lcg_word());
    reg_read(dev_addr, 1'b0, `DBG_REG_SCRATCH1, "sda_pin word read of SCRATCH1");
    reg_read(dev_addr, 1'b1, `DBG_REG_SCRATCH1, "sda_pin byte read of SCRATCH1");
    end_test("byte write of SCRATCH1");

    reg_read(dev_addr, 1'b0, `DBG_REG_ID, "sda_pin read of ID");
    reg_write(dev_addr, 1'b0, `DBG_REG_ID, lcg_word());
    reg_read(dev_addr, 1'b0, `DBG_REG_ID, "sda_pin read of ID after write");
    end_test("ID is read-only");

    bus_start();
    send_byte({7'h3B, 1'b0}, ack);           // Nobody answers this one
    check_ack(ack, 1'b0);
    send_byte({1'b1, 1'b0, `DBG_REG_SCRATCH0}, ack);   // Would land in SCRATCH0 if taken
    check_ack(ack, 1'b0);
    send_byte(~ref_s0[7:0], ack);
    check_ack(ack, 1'b0);
    send_byte(~ref_s0[15:8], ack);
    check_ack(ack, 1'b0);
    bus_stop();
    reg_read(dev_addr, 1'b0, `DBG_REG_SCRATCH0, "sda_pin read of SCRATCH0");
    end_test("foreign address ignored");

    reg_write(broadcast_addr, 1'b0, `DBG_REG_SCRATCH0, lcg_word());
    reg_read(broadcast_addr, 1'b0, `DBG_REG_SCRATCH0, "sda_pin broadcast read");
    reg_read(dev_addr, 1'b0, `DBG_REG_SCRATCH0, "sda_pin read of SCRATCH0");
    end_test("broadcast address");

    reg_write(dev_addr, 1'b0, `DBG_REG_MEM_ADDR, 16'd60);
    for (i = 0; i < 8; i++) begin
      reg_write(dev_addr, 1'b0, `DBG_REG_MEM_DATA, lcg_word());   // Crosses 63
    end
    reg_write(dev_addr, 1'b0, `DBG_REG_MEM_ADDR, 16'd60);
    for (i = 0; i < 8; i++) begin
      reg_read(dev_addr, 1'b0, `DBG_REG_MEM_DATA, "sda_pin read of MEM_DATA");
    end
    reg_read(dev_addr, 1'b0, `DBG_REG_MEM_ADDR, "sda_pin read of MEM_ADDR");
    end_test("memory burst with wrap");

    $display("%0d tests run, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule

/* vlog.f */
+incdir+logic
logic/dbg_pkg.sv
logic/dbg_i2c_line_filter.sv
logic/dbg_i2c_slave.sv
logic/dbg_reg_bank.sv
logic/dbg_i2c_top.sv
verif/dbg_i2c_assert.sv
verif/tb_dbg_i2c.sv

/* run.sh */
#!/bin/sh
# Build the debug I2C testbench with Verilator, run it and look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module tb_dbg_i2c -o sim_tb

result=$(./obj_dir/sim_tb 2>&1 || true)
printf '%s\n' "$result"

if printf '%s\n' "$result" | grep -qx "all tests passed"; then
  exit 0
fi
exit 1
